//--- hw/flash_cfg.svh
`ifndef FLASH_CFG_SVH
`define FLASH_CFG_SVH

// ==========================================================================
// Array geometry
// ==========================================================================
`define FLASH_MEM_BYTES     1024
`define FLASH_ADDR_BITS     10
`define FLASH_SECTOR_BYTES  256   // Erase granule for 20h
`define FLASH_PAGE_BYTES    256   // Program wrap boundary for 02h

// ==========================================================================
// Status register and fill values
// ==========================================================================
`define FLASH_STATUS_RESET  8'h40 // QE set and WIP never set
`define FLASH_WEL_BIT       1
`define FLASH_ERASED_BYTE   8'hFF

// JEDEC identification bytes
`define FLASH_ID_MFR        8'hEF
`define FLASH_ID_TYPE       8'h40
`define FLASH_ID_CAP        8'h18

`endif

//--- hw/flash_pkg.sv
`include "flash_cfg.svh"

package flash_pkg;

  // ========================================================================
  // Encodings
  // ========================================================================
  typedef enum logic [7:0] {
    OP_PP        = 8'h02,
    OP_RDSR      = 8'h05,
    OP_WREN      = 8'h06,
    OP_FAST_READ = 8'h0B,
    OP_SE        = 8'h20,
    OP_CE_ALT    = 8'h60,
    OP_RDID      = 8'h9F,
    OP_CE        = 8'hC7
  } flash_opcode_t;

  // Decoder position within one selection
  typedef enum logic [2:0] {
    PH_IDLE,
    PH_ADDR,
    PH_DUMMY,
    PH_DATA_TX,
    PH_DATA_RX,
    PH_IGNORE
  } cmd_phase_t;

  typedef enum logic [3:0] {
    SOP_NONE,
    SOP_WREN,
    SOP_WRITE,
    SOP_ERASE_SECTOR,
    SOP_ERASE_CHIP,
    SOP_CLEAR_WEL,
    SOP_LOAD_STATUS,
    SOP_LOAD_ID,
    SOP_READ          // Array byte for fast read
  } storage_op_t;

  // ========================================================================
  // Stage payloads
  // ========================================================================
  typedef struct packed {
    logic [7:0] data;
    logic       valid;  // One cycle per received byte
    logic       first;  // Opcode byte of the selection
  } rx_byte_t;

  typedef struct packed {
    storage_op_t                 op;
    logic [`FLASH_ADDR_BITS-1:0] addr;
    logic [7:0]                  data;
    logic [1:0]                  id_idx;
  } storage_req_t;

  typedef struct packed {
    logic [7:0] data;
    logic       load;
  } tx_byte_t;

endpackage

//--- hw/spi_bit_receiver.sv
module spi_bit_receiver (
  input  logic                SCK,
  input  logic                rst_n,
  input  logic                cs_n,
  input  logic                si,
  output flash_pkg::rx_byte_t rx
);

  logic [6:0] shift_q;       // Bits 7..1 of the byte in flight
  logic [2:0] bit_cnt_q;
  logic       first_pend_q;  // Next byte completes the opcode

  // MSB first on the rising edge
  always_ff @(posedge SCK or negedge rst_n) begin
    if (!rst_n) begin
      shift_q      <= '0;
      bit_cnt_q    <= '0;
      first_pend_q <= 1'b1;
      rx           <= '0;
    end else if (cs_n) begin
      bit_cnt_q    <= '0;
      first_pend_q <= 1'b1;
      rx.valid     <= 1'b0;
    end else begin
      shift_q   <= {shift_q[5:0], si};
      bit_cnt_q <= bit_cnt_q + 1'b1;
      rx.valid  <= (bit_cnt_q == 3'd7);
      if (bit_cnt_q == 3'd7) begin
        rx.data      <= {shift_q, si};
        rx.first     <= first_pend_q;
        first_pend_q <= 1'b0;
      end
    end
  end

  // Byte strobes are separated by at least one idle cycle
  a_rx_valid_single: assert property (
    @(posedge SCK) disable iff (!rst_n)
    rx.valid |=> !rx.valid
  );

endmodule

//--- hw/flash_cmd_decoder.sv
`include "flash_cfg.svh"

module flash_cmd_decoder (
  input  logic                    SCK,
  input  logic                    rst_n,
  input  logic                    cs_n,
  input  flash_pkg::rx_byte_t     rx,
  output flash_pkg::storage_req_t req,
  output logic                    tx_active
);
  import flash_pkg::*;

  localparam int AW = `FLASH_ADDR_BITS;
  localparam int PW = $clog2(`FLASH_PAGE_BYTES);

  // Response requests go out on the edge that samples bit 7 of a byte so the
  // loaded byte reaches the transmitter on the falling edge of the boundary
  localparam logic [2:0] LOAD_SLOT = 3'd6;

  cmd_phase_t    phase_q;
  flash_opcode_t opcode_q;
  logic [AW-1:0] addr_q;
  logic [AW-1:0] addr_next;
  logic [1:0]    addr_cnt_q;
  logic [1:0]    id_idx_q;
  logic [2:0]    bit_cnt_q;   // Rising edges since select
  logic          load_slot;
  logic          wel_user;    // Command consumes WEL on deselect

  assign addr_next = {addr_q[AW-9:0], rx.data};  // Keep low address bits only
  assign load_slot = (bit_cnt_q == LOAD_SLOT);
  assign wel_user  = opcode_q inside {OP_PP, OP_SE, OP_CE, OP_CE_ALT};

  // ==========================================================================
  // Command phase FSM
  // ==========================================================================
  always_ff @(posedge SCK or negedge rst_n) begin
    if (!rst_n) begin
      phase_q    <= PH_IDLE;
      opcode_q   <= OP_RDSR;
      addr_q     <= '0;
      addr_cnt_q <= '0;
      id_idx_q   <= '0;
      bit_cnt_q  <= '0;
      req        <= '0;
      tx_active  <= 1'b0;
    end else if (cs_n) begin
      phase_q   <= PH_IDLE;
      bit_cnt_q <= '0;
      tx_active <= 1'b0;
      req       <= '0;
      if (phase_q != PH_IDLE && wel_user) begin
        req.op <= SOP_CLEAR_WEL;
      end
    end else begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
      req.op    <= SOP_NONE;
      case (phase_q)
        PH_IDLE: begin
          if (rx.valid && rx.first) begin
            opcode_q   <= flash_opcode_t'(rx.data);
            addr_cnt_q <= '0;
            id_idx_q   <= '0;
            case (rx.data)
              OP_RDSR, OP_RDID: phase_q <= PH_DUMMY;
              OP_FAST_READ, OP_PP, OP_SE: phase_q <= PH_ADDR;
              OP_WREN: begin
                req.op  <= SOP_WREN;
                phase_q <= PH_IGNORE;
              end
              OP_CE, OP_CE_ALT: begin
                req.op  <= SOP_ERASE_CHIP;
                phase_q <= PH_IGNORE;
              end
              default: phase_q <= PH_IGNORE;  // Unknown opcode
            endcase
          end
        end

        PH_ADDR: begin
          if (rx.valid) begin
            addr_q     <= addr_next;
            addr_cnt_q <= addr_cnt_q + 1'b1;
            if (addr_cnt_q == 2'd2) begin
              case (opcode_q)
                OP_FAST_READ: phase_q <= PH_DUMMY;
                OP_PP:        phase_q <= PH_DATA_RX;
                default: begin  // Sector erase
                  req.op   <= SOP_ERASE_SECTOR;
                  req.addr <= addr_next;
                  phase_q  <= PH_IGNORE;
                end
              endcase
            end
          end
        end

        // Dummy byte ends at the first load slot
        PH_DUMMY, PH_DATA_TX: begin
          if (load_slot) begin
            phase_q      <= PH_DATA_TX;
            tx_active    <= 1'b1;
            req.addr     <= addr_q;
            req.id_idx   <= id_idx_q;
            addr_q       <= addr_q + 1'b1;
            if (id_idx_q != 2'd3) begin
              id_idx_q <= id_idx_q + 1'b1;  // Saturates on the FF filler
            end
            case (opcode_q)
              OP_RDSR: req.op <= SOP_LOAD_STATUS;
              OP_RDID: req.op <= SOP_LOAD_ID;
              default: req.op <= SOP_READ;
            endcase
          end
        end

        PH_DATA_RX: begin
          if (rx.valid) begin
            req.op   <= SOP_WRITE;
            req.addr <= addr_q;
            req.data <= rx.data;
            addr_q   <= {addr_q[AW-1:PW], addr_q[PW-1:0] + 1'b1};  // Page wrap
          end
        end

        default: ;  // Wait for deselect
      endcase
    end
  end

  // Requests only come from an active command or an opcode arrival
  a_req_not_idle: assert property (
    @(posedge SCK) disable iff (!rst_n)
    req.op != SOP_NONE |-> $past(phase_q != PH_IDLE || (rx.valid && rx.first))
  );

endmodule

//--- hw/flash_storage.sv
`include "flash_cfg.svh"

module flash_storage (
  input  logic                    SCK,
  input  logic                    rst_n,
  input  flash_pkg::storage_req_t req,
  output flash_pkg::tx_byte_t     tx
);
  import flash_pkg::*;

  localparam int AW = `FLASH_ADDR_BITS;
  localparam int SW = $clog2(`FLASH_SECTOR_BYTES);

  logic [7:0]                  mem [`FLASH_MEM_BYTES];
  logic [`FLASH_MEM_BYTES-1:0] written_q;     // Clear means erased
  logic [7:0]                  status_q;
  logic [7:0]                  rd_byte_q;
  logic [7:0]                  resp_q;        // Status or ID byte
  logic                        from_array_q;
  logic                        hit_q;
  logic                        load_q;
  logic                        wel;
  logic                        wr_en;
  logic [AW-1:0]               sector_base;

  assign wel         = status_q[`FLASH_WEL_BIT];
  assign wr_en       = (req.op == SOP_WRITE) && wel;
  assign sector_base = {req.addr[AW-1:SW], {SW{1'b0}}};

  function automatic logic [7:0] id_byte(input logic [1:0] idx);
    case (idx)
      2'd0:    return `FLASH_ID_MFR;
      2'd1:    return `FLASH_ID_TYPE;
      2'd2:    return `FLASH_ID_CAP;
      default: return `FLASH_ERASED_BYTE;
    endcase
  endfunction

  // ==========================================================================
  // Byte array
  // ==========================================================================
  always_ff @(posedge SCK) begin
    if (wr_en) begin
      mem[req.addr] <= req.data;
    end
    rd_byte_q <= mem[req.addr];
  end

  // ==========================================================================
  // Flags, status and response select
  // ==========================================================================
  always_ff @(posedge SCK or negedge rst_n) begin
    if (!rst_n) begin
      written_q    <= '0;
      status_q     <= `FLASH_STATUS_RESET;
      resp_q       <= '0;
      from_array_q <= 1'b0;
      hit_q        <= 1'b0;
      load_q       <= 1'b0;
    end else begin
      load_q <= 1'b0;
      case (req.op)
        SOP_WREN:      status_q[`FLASH_WEL_BIT] <= 1'b1;
        SOP_CLEAR_WEL: status_q[`FLASH_WEL_BIT] <= 1'b0;
        SOP_WRITE: begin
          if (wel) begin
            written_q[req.addr] <= 1'b1;
          end
        end
        SOP_ERASE_SECTOR: begin
          if (wel) begin
            written_q[sector_base +: `FLASH_SECTOR_BYTES] <= '0;
          end
        end
        SOP_ERASE_CHIP: begin
          if (wel) begin
            written_q <= '0;
          end
        end
        SOP_LOAD_STATUS: begin
          resp_q       <= status_q;
          from_array_q <= 1'b0;
          load_q       <= 1'b1;
        end
        SOP_LOAD_ID: begin
          resp_q       <= id_byte(req.id_idx);
          from_array_q <= 1'b0;
          load_q       <= 1'b1;
        end
        SOP_READ: begin
          hit_q        <= written_q[req.addr];  // Pairs with rd_byte_q
          from_array_q <= 1'b1;
          load_q       <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign tx.data = from_array_q ? (hit_q ? rd_byte_q : `FLASH_ERASED_BYTE) : resp_q;
  assign tx.load = load_q;

endmodule

//--- hw/spi_bit_transmitter.sv
module spi_bit_transmitter (
  input  logic                SCK,
  input  logic                rst_n,
  input  logic                cs_n,
  input  flash_pkg::tx_byte_t tx,
  input  logic                tx_active,
  output logic                so,
  output logic                so_oe
);

  logic [7:0] shift_q;

  // ==========================================================================
  // Falling edge shifter
  // ==========================================================================
  // Deselect is seen here half a cycle before the rising-edge stages
  always_ff @(negedge SCK or negedge rst_n) begin
    if (!rst_n) begin
      shift_q <= '1;
      so_oe   <= 1'b0;
    end else if (cs_n || !tx_active) begin
      shift_q <= '1;
      so_oe   <= 1'b0;
    end else if (tx.load) begin
      shift_q <= tx.data;  // Bit 7 drives so right away
      so_oe   <= 1'b1;
    end else begin
      shift_q <= {shift_q[6:0], 1'b1};
    end
  end

  assign so = shift_q[7];

  // Output released before the first rising edge of a deselect
  a_oe_off_when_idle: assert property (
    @(posedge SCK) disable iff (!rst_n)
    cs_n |-> !so_oe
  );

endmodule

//--- hw/flash_device_top.sv
module flash_device_top (
  input  logic SCK,
  input  logic rst_n,
  input  logic cs_n,
  input  logic si,
  output logic so,
  output logic so_oe
);
  import flash_pkg::*;

  rx_byte_t     rx;
  storage_req_t req;
  tx_byte_t     tx;
  logic         tx_active;

  // ==========================================================================
  // Four stage pipeline from si to so
  // ==========================================================================
  spi_bit_receiver u_rx (
    .SCK   (SCK),
    .rst_n (rst_n),
    .cs_n  (cs_n),
    .si    (si),
    .rx    (rx)
  );

  flash_cmd_decoder u_dec (
    .SCK       (SCK),
    .rst_n     (rst_n),
    .cs_n      (cs_n),
    .rx        (rx),
    .req       (req),
    .tx_active (tx_active)
  );

  flash_storage u_mem (
    .SCK   (SCK),
    .rst_n (rst_n),
    .req   (req),
    .tx    (tx)
  );

  spi_bit_transmitter u_tx (
    .SCK       (SCK),
    .rst_n     (rst_n),
    .cs_n      (cs_n),
    .tx        (tx),
    .tx_active (tx_active),
    .so        (so),
    .so_oe     (so_oe)
  );

endmodule

//--- verification/flash_tb_tasks.svh
`ifndef FLASH_TB_TASKS_SVH
`define FLASH_TB_TASKS_SVH

// ==========================================================================
// SPI bus level
// ==========================================================================
// Every task starts and ends 1 unit after a rising edge
task automatic send_byte(input logic [7:0] b);
  for (int i = 7; i >= 0; i--) begin
    cs_n = 1'b0;
    si   = b[i];  // MSB first
    @(posedge SCK);
    #1;
  end
endtask

task automatic send_addr(input logic [AW-1:0] addr);
  logic [23:0] a24;
  a24 = 24'(addr);
  send_byte(a24[23:16]);
  send_byte(a24[15:8]);
  send_byte(a24[7:0]);
endtask

// Up to eight response bits of one byte
task automatic check_bits(input logic [7:0] b, input int nbits);
  exp_byte    = b;
  resp_window = 1'b1;
  si          = 1'b0;
  for (int i = 7; i >= 0 && i > 7 - nbits; i--) begin
    exp_bit = b[i];
    @(posedge SCK);
    #1;
  end
endtask

// Requests from the last byte need one more edge with cs_n low
task automatic end_select(input logic settle);
  if (settle) begin
    @(posedge SCK);
    #1;
  end
  cs_n        = 1'b1;
  resp_window = 1'b0;
  si          = 1'b0;
  repeat (2) @(posedge SCK);
  #1;
endtask

// ==========================================================================
// Commands and reference model updates
// ==========================================================================
function automatic logic [7:0] expected_status();
  logic [7:0] st;
  st    = 8'h40;    // QE set, WIP always clear
  st[1] = ref_wel;  // WEL
  return st;
endfunction

task automatic write_enable();
  send_byte(8'h06);
  end_select(1'b1);
  ref_wel = 1'b1;
endtask

task automatic read_status(input int nbits);
  send_byte(8'h05);
  send_byte(8'h00);  // Dummy
  for (int k = 0; k < nbits; k += 8) begin
    check_bits(expected_status(), nbits - k);
  end
  end_select(1'b0);
endtask

task automatic read_id(input int nbits);
  logic [7:0] idb;
  send_byte(8'h9F);
  send_byte(8'h00);
  for (int k = 0; k < nbits; k += 8) begin
    case (k / 8)
      0:       idb = 8'hEF;
      1:       idb = 8'h40;
      2:       idb = 8'h18;
      default: idb = 8'hFF;  // Filler after the ID
    endcase
    check_bits(idb, nbits - k);
  end
  end_select(1'b0);
endtask

task automatic fast_read(input logic [AW-1:0] addr, input int nbits);
  logic [AW-1:0] a;
  send_byte(8'h0B);
  send_addr(addr);
  send_byte(8'h00);
  a = addr;
  for (int k = 0; k < nbits; k += 8) begin
    check_bits(ref_mem[a], nbits - k);
    a = a + 1'b1;  // Wraps at the array end
  end
  end_select(1'b0);
endtask

task automatic page_program(input logic [AW-1:0] addr);
  logic [AW-1:0] a;
  int            base;
  int            offs;
  send_byte(8'h02);
  send_addr(addr);
  foreach (pp_data[k]) begin
    send_byte(pp_data[k]);
  end
  end_select(1'b1);
  base = int'(addr) - int'(addr) % `FLASH_PAGE_BYTES;
  offs = int'(addr) % `FLASH_PAGE_BYTES;
  if (ref_wel) begin
    foreach (pp_data[k]) begin
      a          = AW'(base + (offs + k) % `FLASH_PAGE_BYTES);
      ref_mem[a] = pp_data[k];
    end
  end
  ref_wel = 1'b0;
endtask

task automatic sector_erase(input logic [AW-1:0] addr);
  logic [AW-1:0] a;
  send_byte(8'h20);
  send_addr(addr);
  end_select(1'b1);
  if (ref_wel) begin
    a = AW'(int'(addr) - int'(addr) % `FLASH_SECTOR_BYTES);
    repeat (`FLASH_SECTOR_BYTES) begin
      ref_mem[a] = 8'hFF;
      a          = a + 1'b1;
    end
  end
  ref_wel = 1'b0;
endtask

task automatic chip_erase(input logic [7:0] opcode);
  send_byte(opcode);
  end_select(1'b1);
  if (ref_wel) begin
    ref_mem = '{default: 8'hFF};
  end
  ref_wel = 1'b0;
endtask

task automatic fill_payload(input int n);
  logic [31:0] rnd;
  pp_data.delete();
  repeat (n) begin
    rnd = $urandom;
    pp_data.push_back(rnd[7:0]);
  end
endtask

// ==========================================================================
// Test sequence
// ==========================================================================
task automatic begin_test(input string name);
  cur_test      = name;
  test_err_base = err_count;
endtask

task automatic end_test();
  tests_run++;
  if (err_count == test_err_base) begin
    $display("test %0d %s: ok", tests_run, cur_test);
  end else begin
    tests_bad++;
    $display("test %0d %s: %0d mismatches", tests_run, cur_test,
             err_count - test_err_base);
  end
endtask

task automatic run_tests();
  logic [31:0]   rnd;
  logic [AW-1:0] page;
  logic [AW-1:0] sect_a;
  logic [AW-1:0] sect_b;

  begin_test("status after reset");
  read_status(24);
  read_status(16);
  end_test();

  begin_test("identification");
  read_id(48);
  end_test();

  begin_test("write enable latch");
  write_enable();
  read_status(16);
  fill_payload(4);
  page_program(10'h3F0);
  read_status(8);  // WEL gone after the program
  end_test();

  begin_test("page program");
  rnd  = $urandom;
  page = {rnd[1:0], 8'h00};
  fill_payload(16);
  page_program(page + 10'hFC);  // No WREN so the page stays erased
  fast_read(page + 10'hFC, 32);
  write_enable();
  page_program(page + 10'hFC);
  fast_read(page + 10'hFC, 32);
  fast_read(page, 96);          // Tail that wrapped to the page start
  end_test();

  begin_test("sector and chip erase");
  rnd    = $urandom;
  sect_a = {rnd[1:0], 8'h00};
  sect_b = {rnd[1:0] ^ 2'b01, 8'h00};  // Neighbor sector
  fill_payload(8);
  write_enable();
  page_program(sect_a + 10'h40);
  write_enable();
  page_program(sect_b + 10'h40);
  write_enable();
  sector_erase(sect_a + 10'h5A);
  fast_read(sect_a + 10'h40, 64);
  fast_read(sect_b + 10'h40, 64);
  chip_erase(8'hC7);  // Ignored with WEL clear
  fast_read(sect_b + 10'h40, 64);
  write_enable();
  chip_erase(8'h60);
  fast_read(sect_b + 10'h40, 64);
  end_test();

  begin_test("deselect mid response");
  read_status(3);
  read_id(32);
  read_id(12);
  write_enable();
  read_status(8);
  fast_read(10'h3F0, 5);
  read_status(8);
  end_test();
endtask

`endif

//--- verification/flash_tb.sv
`include "flash_cfg.svh"

module flash_tb;

  localparam int AW          = `FLASH_ADDR_BITS;
  localparam int CYCLE_LIMIT = 4000;  // About twice the full test sequence

  logic SCK;
  logic rst_n;
  logic cs_n;
  logic si;
  logic so;
  logic so_oe;

  // Reference model state
  logic [7:0] ref_mem [`FLASH_MEM_BYTES];
  logic       ref_wel;
  logic [7:0] pp_data [$];  // Payload of the next page program

  // Expected response bit, meaningful while resp_window is high
  logic       resp_window;
  logic       exp_bit;
  logic [7:0] exp_byte;

  string cur_test;
  int    err_count;
  int    test_err_base;
  int    tests_run;
  int    tests_bad;
  int    cycle_count = 0;

  flash_device_top dut0 (
    .SCK   (SCK),
    .rst_n (rst_n),
    .cs_n  (cs_n),
    .si    (si),
    .so    (so),
    .so_oe (so_oe)
  );

  initial begin
    SCK = 1'b0;
    forever #5 SCK = ~SCK;
  end

  // ========================================================================
  // Response checks against the model
  // ========================================================================
  so_matches_model: assert property (
    @(posedge SCK) disable iff (!rst_n)
    resp_window |-> (so == exp_bit)
  ) else begin
    err_count++;
    $display("error %0t: so is %b, expected %b from byte %h",
             $time, so, exp_bit, exp_byte);
  end

  // Driver enabled exactly inside response windows
  oe_matches_window: assert property (
    @(posedge SCK) disable iff (!rst_n)
    so_oe == resp_window
  ) else begin
    err_count++;
    $display("error %0t: so_oe is %b, response window is %b",
             $time, so_oe, resp_window);
  end

  always @(posedge SCK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  `include "flash_tb_tasks.svh"

  initial begin
    void'($urandom(87));
    rst_n       = 1'b0;
    cs_n        = 1'b1;
    si          = 1'b0;
    resp_window = 1'b0;
    exp_bit     = 1'b1;
    exp_byte    = 8'hFF;
    ref_wel     = 1'b0;
    ref_mem     = '{default: 8'hFF};  // Everything reads erased
    err_count   = 0;
    tests_run   = 0;
    tests_bad   = 0;
    repeat (10) @(posedge SCK);
    #1;
    rst_n = 1'b1;
    @(posedge SCK);
    #1;
    run_tests();
    $display("tests %0d, tests with errors %0d, mismatches %0d",
             tests_run, tests_bad, err_count);
    if (tests_bad == 0 && err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
+incdir+verification
hw/flash_pkg.sv
hw/spi_bit_receiver.sv
hw/flash_cmd_decoder.sv
hw/flash_storage.sv
hw/spi_bit_transmitter.sv
hw/flash_device_top.sv
verification/flash_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the flash testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module flash_tb -f project.f -o flash_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/flash_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -qx "sim passed" sim.log && exit 0 || exit 1
